/* Makefile */
# Verilator build and run of the hss link multiplexer testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = hss_mux_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/hss_mux_assert.sv */
// ------------------------------
// hss link multiplexer assertions
// grant, link hold, buffer and tfrm rules
// ------------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module hss_mux_assert (
  input logic                            clk,
  input logic                            arst_n,
  input logic [`NUM_CHANS-1:0]           pkt_rdy,
  input logic [`PKT_BITS-1:0]            hsl_data,
  input logic                            hsl_kchr,
  input logic                            hsl_rdy,
  input logic                            tfrm,
  input logic                            push_vld,
  input logic                            push_rdy,
  input logic                            pop_vld,
  input logic                            pop_rdy,
  input hss_mux_pkg::tx_state_t          tx_state
);

  // count of failed assertions
  int assert_fails = 0;

  // buffer fill level rebuilt from the two handshakes
  int occ;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      occ <= 0;
    end else begin
      occ <= occ + int'(push_vld && push_rdy) - int'(pop_vld && pop_rdy);
    end
  end

  // at most one channel granted
  a_rdy_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(pkt_rdy))
    else begin assert_fails++; $error("pkt_rdy granted to more than one channel"); end

  // link word frozen while the link is not ready
  a_link_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !hsl_rdy |=> $stable(hsl_data) && $stable(hsl_kchr))
    else begin assert_fails++; $error("link word changed while hsl_rdy was low"); end

  // ------------------------------
  // frame buffer bounds
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    push_vld && push_rdy |-> occ < `BUF_DEPTH)
    else begin assert_fails++; $error("frame buffer pushed while full"); end

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    pop_vld && pop_rdy |-> occ > 0)
    else begin assert_fails++; $error("frame buffer popped while empty"); end

  // tfrm only after an accepted data word
  a_tfrm_cause: assert property (@(posedge clk) disable iff (!arst_n)
    tfrm |-> $past(tx_state == hss_mux_pkg::TX_DATA && hsl_rdy))
    else begin assert_fails++; $error("tfrm without an accepted data word"); end

endmodule

bind hss_mux_top hss_mux_assert chk (
  .clk (clk), .arst_n (arst_n), .pkt_rdy (pkt_rdy),
  .hsl_data (hsl_data), .hsl_kchr (hsl_kchr), .hsl_rdy (hsl_rdy), .tfrm (tfrm),
  .push_vld (asm_frm.vld), .push_rdy (asm_frm.rdy),
  .pop_vld (buf_frm.vld), .pop_rdy (buf_frm.rdy),
  .tx_state (ft.state)
);

/* bench/hss_mux_tb.sv */
// ------------------------------
// hss link multiplexer testbench
// directed tests, a link monitor and a
// model of arbitration and sequence tagging
// ------------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module hss_mux_tb;

  // far above the few hundred cycles that all tests take
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RAND_PKTS      = 24;
  localparam int STALL_WINDOW   = 8;

  logic                                 clk = 1'b0;
  logic                                 arst_n;
  logic [`NUM_CHANS-1:0][`PKT_BITS-1:0] pkt_data;
  logic [`NUM_CHANS-1:0]                pkt_vld;
  logic [`NUM_CHANS-1:0]                pkt_rdy;
  logic [`PKT_BITS-1:0]                 hsl_data;
  logic                                 hsl_kchr;
  logic                                 hsl_rdy;
  logic                                 tfrm;

  // model and monitor state
  hss_mux_pkg::frame_t  exp_q [$];
  hss_mux_pkg::frame_t  rx_q [$];
  hss_mux_pkg::frame_t  hdr;
  logic                 in_frame  = 1'b0;
  int                   last_gnt  = `NUM_CHANS - 1;
  logic [`SEQ_BITS-1:0] seq_model = '0;
  int                   idle_cnt  = 0;
  int                   tfrm_cnt  = 0;
  int                   err_cnt   = 0;
  int                   pass_cnt  = 0;
  int                   fail_cnt  = 0;
  logic [15:0]          lfsr      = 16'd65;

  hss_mux_top uut (
    .clk (clk), .arst_n (arst_n),
    .pkt_data (pkt_data), .pkt_vld (pkt_vld), .pkt_rdy (pkt_rdy),
    .hsl_data (hsl_data), .hsl_kchr (hsl_kchr), .hsl_rdy (hsl_rdy), .tfrm (tfrm)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    err_cnt++;
    $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
  endtask

  task automatic report_problem(input string msg);
    err_cnt++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // received frame against the oldest accepted packet
  task automatic check_frame(input hss_mux_pkg::frame_t got);
    hss_mux_pkg::frame_t want;
    rx_q.push_back(got);
    if (exp_q.size() == 0) begin
      report_problem("frame on the link with no packet accepted");
    end else begin
      want = exp_q.pop_front();
      if (got.channel !== want.channel)
        report_mismatch("frame channel", 32'(want.channel), 32'(got.channel));
      if (got.seq !== want.seq)
        report_mismatch("frame seq", 32'(want.seq), 32'(got.seq));
      if (got.data !== want.data)
        report_mismatch("frame data", want.data, got.data);
    end
  endtask

  // ------------------------------
  // link monitor samples mid-cycle where all signals are settled
  always @(negedge clk) begin : link_monitor
    int                    c;
    int                    steps;
    logic [`NUM_CHANS-1:0] want_rdy;
    hss_mux_pkg::frame_t   f;
    if (arst_n) begin
      // grant must follow round robin from the last grant
      if (pkt_rdy != '0) begin
        c     = (last_gnt + 1) % `NUM_CHANS;
        steps = 0;
        while (!pkt_vld[c] && steps < `NUM_CHANS) begin
          c = (c + 1) % `NUM_CHANS;
          steps++;
        end
        if (steps == `NUM_CHANS) begin
          report_problem("pkt_rdy raised with no channel valid");
        end else begin
          want_rdy    = '0;
          want_rdy[c] = 1'b1;
          if (pkt_rdy !== want_rdy)
            report_mismatch("pkt_rdy", 32'(want_rdy), 32'(pkt_rdy));
          f.channel = `CHAN_BITS'(c);
          f.seq     = seq_model;
          f.data    = pkt_data[c];
          exp_q.push_back(f);
          last_gnt  = c;
          seq_model = seq_model + `SEQ_BITS'(1);
        end
      end
      if (tfrm)
        tfrm_cnt++;
      // words taken by the link
      if (hsl_rdy) begin
        if (in_frame) begin
          if (hsl_kchr !== hss_mux_pkg::KIND_DATA)
            report_mismatch("hsl_kchr", 32'(hss_mux_pkg::KIND_DATA), 32'(hsl_kchr));
          hdr.data = hsl_data;
          in_frame = 1'b0;
          check_frame(hdr);
        end else if (hsl_kchr === hss_mux_pkg::KIND_CTRL &&
                     hsl_data[`PKT_BITS-1 -: 8] == `SOF_CODE) begin
          hdr.channel = hsl_data[8 +: `CHAN_BITS];
          hdr.seq     = hsl_data[0 +: `SEQ_BITS];
          in_frame    = 1'b1;
        end else if (hsl_kchr === hss_mux_pkg::KIND_CTRL && hsl_data === `IDLE_WORD) begin
          idle_cnt++;
        end else begin
          report_problem("unexpected word on the link");
        end
      end
    end
  end

  // offer one packet and hold it until taken
  task automatic send_packet(input int ch, input logic [31:0] data);
    pkt_data[ch] = data;
    pkt_vld[ch]  = 1'b1;
    @(negedge clk);
    while (!pkt_rdy[ch])
      @(negedge clk);
    @(posedge clk);
    #2;
    pkt_vld[ch] = 1'b0;
  endtask

  // wait for n frames in total and the cycle that carries tfrm
  task automatic wait_frames(input int n);
    while (rx_q.size() < n)
      @(posedge clk);
    @(posedge clk);
    #2;
  endtask

  // ------------------------------
  // directed tests
  task automatic idle_after_reset();
    int errs0;
    int id0;
    errs0 = err_cnt;
    id0   = idle_cnt;
    repeat (20) begin
      @(negedge clk);
      if (hsl_data !== `IDLE_WORD)
        report_mismatch("hsl_data", `IDLE_WORD, hsl_data);
      if (hsl_kchr !== hss_mux_pkg::KIND_CTRL)
        report_mismatch("hsl_kchr", 32'(hss_mux_pkg::KIND_CTRL), 32'(hsl_kchr));
      if (pkt_rdy !== '0)
        report_mismatch("pkt_rdy", 32'(0), 32'(pkt_rdy));
      if (tfrm !== 1'b0)
        report_mismatch("tfrm", 32'(0), 32'(tfrm));
    end
    @(posedge clk);
    #2;
    if (idle_cnt - id0 != 20)
      report_mismatch("idle word count", 32'(20), 32'(idle_cnt - id0));
    close_test("idle_after_reset", errs0);
  endtask

  task automatic single_packet();
    int                  errs0;
    int                  rx0;
    int                  tf0;
    int                  id0;
    logic [31:0]         d;
    hss_mux_pkg::frame_t f;
    errs0 = err_cnt;
    rx0   = rx_q.size();
    tf0   = tfrm_cnt;
    d     = rand_bits(32);
    send_packet(2, d);
    wait_frames(rx0 + 1);
    f = rx_q[rx0];
    if (f.channel !== 2'd2)
      report_mismatch("header channel", 32'(2), 32'(f.channel));
    if (f.seq !== '0)
      report_mismatch("header seq", 32'(0), 32'(f.seq));
    if (f.data !== d)
      report_mismatch("data word", d, f.data);
    // link falls back to idle words
    id0 = idle_cnt;
    repeat (4) @(posedge clk);
    #2;
    if (idle_cnt - id0 != 4)
      report_mismatch("idle word count", 32'(4), 32'(idle_cnt - id0));
    if (tfrm_cnt - tf0 != 1)
      report_mismatch("tfrm pulses", 32'(1), 32'(tfrm_cnt - tf0));
    close_test("single_packet", errs0);
  endtask

  task automatic all_channels_busy();
    int                    errs0;
    int                    rx0;
    int                    left [`NUM_CHANS];
    int                    remaining;
    logic [`NUM_CHANS-1:0] took;
    logic [`SEQ_BITS-1:0]  base_seq;
    hss_mux_pkg::frame_t   f;
    errs0 = err_cnt;
    // a grant on channel 3 puts channel 0 next in line
    rx0 = rx_q.size();
    send_packet(3, rand_bits(32));
    wait_frames(rx0 + 1);
    rx0       = rx_q.size();
    base_seq  = seq_model;
    remaining = 2 * `NUM_CHANS;
    for (int ch = 0; ch < `NUM_CHANS; ch++) begin
      left[ch]     = 2;
      pkt_data[ch] = rand_bits(32);
      pkt_vld[ch]  = 1'b1;
    end
    while (remaining > 0) begin
      @(negedge clk);
      took = pkt_vld & pkt_rdy;
      @(posedge clk);
      #2;
      for (int ch = 0; ch < `NUM_CHANS; ch++) begin
        if (took[ch]) begin
          left[ch]--;
          remaining--;
          if (left[ch] == 0)
            pkt_vld[ch] = 1'b0;
          else
            pkt_data[ch] = rand_bits(32);
        end
      end
    end
    wait_frames(rx0 + 2 * `NUM_CHANS);
    for (int k = 0; k < 2 * `NUM_CHANS; k++) begin
      f = rx_q[rx0 + k];
      if (f.channel !== `CHAN_BITS'(k % `NUM_CHANS))
        report_mismatch("frame channel", 32'(k % `NUM_CHANS), 32'(f.channel));
      if (f.seq !== base_seq + `SEQ_BITS'(k))
        report_mismatch("frame seq", 32'(base_seq + `SEQ_BITS'(k)), 32'(f.seq));
    end
    close_test("all_channels_busy", errs0);
  endtask

  task automatic random_traffic();
    int   errs0;
    int   rx0;
    int   tf0;
    int   sent;
    int   ch;
    logic took;
    errs0 = err_cnt;
    rx0   = rx_q.size();
    tf0   = tfrm_cnt;
    sent  = 0;
    ch    = int'(rand_bits(2));
    pkt_data[ch] = rand_bits(32);
    pkt_vld[ch]  = 1'b1;
    while (sent < RAND_PKTS) begin
      @(negedge clk);
      took = pkt_vld[ch] && pkt_rdy[ch];
      @(posedge clk);
      #2;
      hsl_rdy = rand_bits(1) != 0;
      if (took) begin
        pkt_vld[ch] = 1'b0;
        sent++;
        if (sent < RAND_PKTS) begin
          ch           = int'(rand_bits(2));
          pkt_data[ch] = rand_bits(32);
          pkt_vld[ch]  = 1'b1;
        end
      end
    end
    hsl_rdy = 1'b1;
    wait_frames(rx0 + RAND_PKTS);
    if (rx_q.size() - rx0 != RAND_PKTS)
      report_mismatch("frames received", 32'(RAND_PKTS), 32'(rx_q.size() - rx0));
    if (exp_q.size() != 0)
      report_problem("accepted packets missing from the link");
    if (tfrm_cnt - tf0 != RAND_PKTS)
      report_mismatch("tfrm pulses", 32'(RAND_PKTS), 32'(tfrm_cnt - tf0));
    close_test("random_traffic", errs0);
  endtask

  task automatic link_stall();
    int   errs0;
    int   rx0;
    int   accepted;
    int   quiet;
    logic took;
    errs0    = err_cnt;
    rx0      = rx_q.size();
    accepted = 0;
    quiet    = 0;
    hsl_rdy     = 1'b0;
    pkt_data[1] = rand_bits(32);
    pkt_vld[1]  = 1'b1;
    // keep offering until the path stops taking packets
    while (quiet < STALL_WINDOW) begin
      @(negedge clk);
      took = pkt_rdy[1];
      // link keeps the idle word it held when the stall began
      if (hsl_data !== `IDLE_WORD)
        report_mismatch("hsl_data", `IDLE_WORD, hsl_data);
      if (hsl_kchr !== hss_mux_pkg::KIND_CTRL)
        report_mismatch("hsl_kchr", 32'(hss_mux_pkg::KIND_CTRL), 32'(hsl_kchr));
      @(posedge clk);
      #2;
      if (took) begin
        accepted++;
        quiet       = 0;
        pkt_data[1] = rand_bits(32);
      end else begin
        quiet++;
      end
    end
    if (accepted != `BUF_DEPTH + 1)
      report_mismatch("packets accepted while stalled", 32'(`BUF_DEPTH + 1), 32'(accepted));
    // release the link so the packet still on offer goes through
    hsl_rdy = 1'b1;
    @(negedge clk);
    while (!pkt_rdy[1])
      @(negedge clk);
    @(posedge clk);
    #2;
    pkt_vld[1] = 1'b0;
    wait_frames(rx0 + accepted + 1);
    if (exp_q.size() != 0)
      report_problem("stalled packets missing from the link");
    close_test("link_stall", errs0);
  endtask

  // ------------------------------
  initial begin
    arst_n   = 1'b0;
    pkt_data = '0;
    pkt_vld  = '0;
    hsl_rdy  = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    idle_after_reset();
    single_packet();
    all_channels_busy();
    random_traffic();
    link_stall();
    if (uut.chk.assert_fails != 0)
      report_problem("concurrent assertions failed");
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/hss_mux_pkg.sv
logic/frame_if.sv
logic/frame_assembler.sv
logic/frame_buffer.sv
logic/frame_tx.sv
logic/hss_mux_top.sv
bench/hss_mux_assert.sv
bench/hss_mux_tb.sv

/* logic/frame_assembler.sv */
// ----------------------------
// frame assembler
// round-robin pick of a packet channel,
// tags the packet with channel and sequence
// number and registers it as a frame
// ----------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module frame_assembler (
  input  logic                                 clk,
  input  logic                                 arst_n,

  // packet channels
  input  logic [`NUM_CHANS-1:0][`PKT_BITS-1:0] pkt_data,
  input  logic [`NUM_CHANS-1:0]                pkt_vld,
  output logic [`NUM_CHANS-1:0]                pkt_rdy,

  // frames towards the buffer
  frame_if.src                                 frm_out
);

  // arbiter state
  logic [`CHAN_BITS-1:0] last_gnt;
  logic [`CHAN_BITS-1:0] gnt_idx;
  logic                  gnt_found;
  logic                  arb_en;
  logic                  accept;

  // sequence tag and output register
  logic [`SEQ_BITS-1:0]  seq_cnt;
  hss_mux_pkg::frame_t   frm_q;
  logic                  vld_q;

  // ----------------------------
  // round-robin arbiter
  // ----------------------------
  // search upward from the channel after the last grant
  always_comb begin
    int cand;
    gnt_found = 1'b0;
    gnt_idx   = last_gnt;
    for (int i = 1; i <= `NUM_CHANS; i++) begin
      cand = (int'(last_gnt) + i) % `NUM_CHANS;
      if (!gnt_found && pkt_vld[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand[`CHAN_BITS-1:0];
      end
    end
  end

  // rdy from the buffer means the register is free or being emptied
  assign accept = arb_en && frm_out.rdy && gnt_found;

  // one-hot ready to the winning channel only
  always_comb begin
    pkt_rdy = '0;
    if (accept) begin
      pkt_rdy[gnt_idx] = 1'b1;
    end
  end

  // ----------------------------
  // control state
  // ----------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arb_en   <= 1'b0;
      last_gnt <= `CHAN_BITS'(`NUM_CHANS - 1);
      seq_cnt  <= '0;
      vld_q    <= 1'b0;
    end else begin
      // arbiter wakes up on the first edge out of reset
      arb_en <= 1'b1;
      if (accept) begin
        last_gnt <= gnt_idx;
        seq_cnt  <= seq_cnt + 1'b1;
        vld_q    <= 1'b1;
      end else if (frm_out.rdy) begin
        vld_q    <= 1'b0;
      end
    end
  end

  // frame register, loaded on the accept edge
  always_ff @(posedge clk) begin
    if (accept) begin
      frm_q.channel <= gnt_idx;
      frm_q.seq     <= seq_cnt;
      frm_q.data    <= pkt_data[gnt_idx];
    end
  end

  assign frm_out.frm = frm_q;
  assign frm_out.vld = vld_q;

endmodule

/* logic/frame_buffer.sv */
// ----------------------------
// frame buffer
// circular FIFO of frames between the
// assembler and the transmitter
// ----------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module frame_buffer (
  input  logic clk,
  input  logic arst_n,

  // frames from the assembler
  frame_if.dst frm_in,

  // frames to the transmitter
  frame_if.src frm_out
);

  localparam int PTR_BITS = $clog2(`BUF_DEPTH);
  localparam int CNT_BITS = PTR_BITS + 1;

  // storage
  hss_mux_pkg::frame_t mem [`BUF_DEPTH];

  // pointers and fill level
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  // ----------------------------
  // status and handshakes
  // ----------------------------
  assign full  = (count == CNT_BITS'(`BUF_DEPTH));
  assign empty = (count == '0);

  assign frm_in.rdy  = !full;
  assign frm_out.vld = !empty;
  // head entry is always on the output
  assign frm_out.frm = mem[rd_ptr];

  assign push = frm_in.vld && frm_in.rdy;
  assign pop  = frm_out.vld && frm_out.rdy;

  // pointers wrap by themselves, depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push with pop leaves the level alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= frm_in.frm;
    end
  end

endmodule

/* logic/frame_if.sv */
// ----------------------------
// frame channel
// one frame with a vld/rdy handshake
// ----------------------------
`timescale 1ns/1ns

interface frame_if;

  // frame payload, held while vld is up
  hss_mux_pkg::frame_t frm;

  // handshake pair
  logic vld;
  logic rdy;

  // producer side
  modport src (
    output frm,
    output vld,
    input  rdy
  );

  // consumer side
  modport dst (
    input  frm,
    input  vld,
    output rdy
  );

endinterface

/* logic/frame_tx.sv */
// ----------------------------
// frame transmitter
// sends each frame as a header word and a
// data word, fills gaps with idle words and
// holds the link word while hsl_rdy is low
// ----------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module frame_tx (
  input  logic                 clk,
  input  logic                 arst_n,

  // frames from the buffer
  frame_if.dst                 frm_in,

  // high-speed link
  output logic [`PKT_BITS-1:0] hsl_data,
  output logic                 hsl_kchr,
  input  logic                 hsl_rdy,

  // frame completed on the link
  output logic                 tfrm
);

  hss_mux_pkg::tx_state_t  state;
  hss_mux_pkg::word_kind_t kind;

  // held copy of the frame in flight
  hss_mux_pkg::frame_t     frm_q;

  logic                    load;
  logic [`PKT_BITS-1:0]    hdr_word;

  // ----------------------------
  // frame intake
  // ----------------------------
  // ready for a new frame when the idle or data word is accepted
  assign frm_in.rdy = hsl_rdy && (state != hss_mux_pkg::TX_HDR);
  assign load       = frm_in.vld && frm_in.rdy;

  // word sequencing, moves only on accepted link words
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= hss_mux_pkg::TX_IDLE;
      tfrm  <= 1'b0;
    end else begin
      // data word leaving marks the frame as done
      tfrm <= hsl_rdy && (state == hss_mux_pkg::TX_DATA);
      if (hsl_rdy) begin
        case (state)
          hss_mux_pkg::TX_HDR:  state <= hss_mux_pkg::TX_DATA;
          // idle and data both go on to the next frame if there is one
          default:              state <= load ? hss_mux_pkg::TX_HDR : hss_mux_pkg::TX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frm_q <= frm_in.frm;
    end
  end

  // ----------------------------
  // link word encoding
  // ----------------------------
  // state and frame copy only change on accepted words, so the word holds
  always_comb begin
    hdr_word                 = '0;
    hdr_word[`PKT_BITS-1 -: 8] = `SOF_CODE;
    hdr_word[15:8]           = 8'(frm_q.channel);
    hdr_word[7:0]            = 8'(frm_q.seq);
    case (state)
      hss_mux_pkg::TX_HDR: begin
        hsl_data = hdr_word;
        kind     = hss_mux_pkg::KIND_CTRL;
      end
      hss_mux_pkg::TX_DATA: begin
        hsl_data = frm_q.data;
        kind     = hss_mux_pkg::KIND_DATA;
      end
      default: begin
        hsl_data = `IDLE_WORD;
        kind     = hss_mux_pkg::KIND_CTRL;
      end
    endcase
  end

  assign hsl_kchr = kind;

endmodule

/* logic/hss_mux_config.svh */
// ----------------------------
// hss link multiplexer sizes
// channel count, field widths and link codes
// ----------------------------
`ifndef HSS_MUX_CONFIG_SVH
`define HSS_MUX_CONFIG_SVH

// packet channels and field widths
`define NUM_CHANS 4
`define PKT_BITS  32
`define SEQ_BITS  8
`define CHAN_BITS 2

// frame buffer entries, power of two
`define BUF_DEPTH 4

// link control codes
`define SOF_CODE  8'hFB
`define IDLE_WORD 32'hBCBCBCBC

`endif

/* logic/hss_mux_pkg.sv */
// ----------------------------
// hss link multiplexer types
// frame record, transmitter states and
// link word kinds shared across the design
// ----------------------------

package hss_mux_pkg;

  `include "hss_mux_config.svh"

  // one tagged packet on its way to the link
  typedef struct packed {
    logic [`CHAN_BITS-1:0] channel;
    logic [`SEQ_BITS-1:0]  seq;
    logic [`PKT_BITS-1:0]  data;
  } frame_t;

  // transmitter states
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_HDR  = 2'd1,
    TX_DATA = 2'd2
  } tx_state_t;

  // meaning of the link k-character flag
  typedef enum logic {
    KIND_DATA = 1'b0,
    KIND_CTRL = 1'b1
  } word_kind_t;

endpackage

/* logic/hss_mux_top.sv */
// ----------------------------
// hss link multiplexer, transmit side
// assembler -> frame buffer -> transmitter
// ----------------------------
`timescale 1ns/1ns
`include "hss_mux_config.svh"

module hss_mux_top (
  input  logic                                 clk,
  input  logic                                 arst_n,

  // packet channels
  input  logic [`NUM_CHANS-1:0][`PKT_BITS-1:0] pkt_data,
  input  logic [`NUM_CHANS-1:0]                pkt_vld,
  output logic [`NUM_CHANS-1:0]                pkt_rdy,

  // high-speed link output
  output logic [`PKT_BITS-1:0]                 hsl_data,
  output logic                                 hsl_kchr,
  input  logic                                 hsl_rdy,

  // frame sent pulse
  output logic                                 tfrm
);

  // ----------------------------
  // frame channels
  // ----------------------------
  // assembler to buffer
  frame_if asm_frm ();
  // buffer to transmitter
  frame_if buf_frm ();

  // channel arbiter and tagger
  frame_assembler fa (
    .clk      (clk),
    .arst_n   (arst_n),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .frm_out  (asm_frm.src)
  );

  // frame storage
  frame_buffer fb (
    .clk     (clk),
    .arst_n  (arst_n),
    .frm_in  (asm_frm.dst),
    .frm_out (buf_frm.src)
  );

  // link serialiser
  frame_tx ft (
    .clk      (clk),
    .arst_n   (arst_n),
    .frm_in   (buf_frm.dst),
    .hsl_data (hsl_data),
    .hsl_kchr (hsl_kchr),
    .hsl_rdy  (hsl_rdy),
    .tfrm     (tfrm)
  );

endmodule
